//--- verilog/dma_target_pkg.sv
// DMA write target shared definitions
// Flit layout, header field positions, type codes and Wishbone burst codes
`default_nettype none

package dma_target_pkg;

   // Flit geometry
   localparam int flit_width = 34;
   typedef logic [flit_width-1:0] flit_t;

   // Flit type field and codes
   localparam int flit_type_msb = 33;
   localparam int flit_type_lsb = 32;
   localparam logic [1:0] flit_type_payload = 2'd0;
   localparam logic [1:0] flit_type_header  = 2'd1;
   localparam logic [1:0] flit_type_last    = 2'd2;
   localparam logic [1:0] flit_type_single  = 2'd3;

   // Header fields
   localparam int dest_msb         = 31;
   localparam int dest_lsb         = 27;
   localparam int packet_class_msb = 26;
   localparam int packet_class_lsb = 24;
   localparam int packet_id_msb    = 23;
   localparam int packet_id_lsb    = 20;
   localparam int packet_type_msb  = 19;
   localparam int packet_type_lsb  = 18;
   localparam int req_last_bit     = 17;
   localparam int source_msb       = 16;
   localparam int source_lsb       = 12;

   // Payload and address content
   localparam int content_msb = 31;
   localparam int content_lsb = 0;

   typedef logic [4:0]  tile_id_t;
   typedef logic [3:0]  packet_id_t;
   typedef logic [31:0] word_t;

   // Packet class and type codes
   localparam logic [2:0] packet_class_dma     = 3'd3;
   localparam logic [1:0] packet_type_l2r_req  = 2'd0;
   localparam logic [1:0] packet_type_r2l_req  = 2'd1;
   localparam logic [1:0] packet_type_l2r_resp = 2'd2;

   // Wishbone cycle type identifiers
   localparam logic [2:0] cti_incr = 3'b010;
   localparam logic [2:0] cti_end  = 3'b111;

   // Address step per 32-bit word
   localparam word_t word_bytes = 32'd4;

endpackage

`default_nettype wire

//--- verilog/dma_beat_if.sv
// Write beat channel from the request parser to the Wishbone master
// Carries one addressed word plus the response context of its packet
`timescale 1ns/1ps
`default_nettype none

interface dma_beat_if import dma_target_pkg::*; ();

   logic       valid;
   logic       ready;
   word_t      adr;
   word_t      dat;
   logic       last_beat;
   // Only set on the final beat of a request-last packet
   logic       resp_needed;
   // Response routing, constant over a packet
   tile_id_t   dest;
   packet_id_t packet_id;

   modport parser (output valid, adr, dat, last_beat, resp_needed, dest, packet_id,
                   input ready);
   modport master (input valid, adr, dat, last_beat, resp_needed, dest, packet_id,
                   output ready);

endinterface

`default_nettype wire

//--- verilog/dma_resp_if.sv
// Response request channel from the Wishbone master to the response sender
// One transfer asks for one L2R response flit
`timescale 1ns/1ps
`default_nettype none

interface dma_resp_if import dma_target_pkg::*; ();

   logic       valid;
   logic       ready;
   // Requesting tile
   tile_id_t   dest;
   packet_id_t packet_id;

   modport master (output valid, dest, packet_id,
                   input ready);
   modport sender (input valid, dest, packet_id,
                   output ready);

endinterface

`default_nettype wire

//--- verilog/noc_packet_buffer.sv
// NoC packet buffer
// Circular flit store that only releases flits downstream once the whole
// packet, up to its last or single flit, has been written
`timescale 1ns/1ps
`default_nettype none

module noc_packet_buffer import dma_target_pkg::*; #(
   parameter int packet_depth = 16
) (
   input  wire   clk,
   input  wire   rst,
   input  flit_t in_flit_i,
   input  wire   in_valid_i,
   output logic  in_ready_o,
   output flit_t out_flit_o,
   output logic  out_valid_o,
   input  wire   out_ready_i
);

   localparam int ptr_width = $clog2(packet_depth);
   localparam logic [ptr_width:0] full_count = (ptr_width+1)'(packet_depth);

   flit_t                mem [packet_depth];
   logic [ptr_width-1:0] wr_ptr;
   logic [ptr_width-1:0] rd_ptr;
   // Stored flits and stored complete packets
   logic [ptr_width:0]   flit_count;
   logic [ptr_width:0]   pkt_count;
   logic                 in_xfer;
   logic                 out_xfer;
   logic                 in_last;
   logic                 out_last;

   assign in_ready_o  = (flit_count != full_count);
   assign out_valid_o = (pkt_count != '0);
   assign out_flit_o  = mem[rd_ptr];

   assign in_xfer  = in_valid_i & in_ready_o;
   assign out_xfer = out_valid_o & out_ready_i;

   // Packet ends at a last or single flit, both codes have the high type bit set
   assign in_last  = in_flit_i[flit_type_msb];
   assign out_last = out_flit_o[flit_type_msb];

   // Flit storage, no reset needed
   always_ff @(posedge clk) begin
      if (in_xfer) begin
         mem[wr_ptr] <= in_flit_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         flit_count <= '0;
         pkt_count  <= '0;
      end else begin
         if (in_xfer) wr_ptr <= wr_ptr + 1'b1;
         if (out_xfer) rd_ptr <= rd_ptr + 1'b1;
         // Occupancy in flits
         case ({in_xfer, out_xfer})
            2'b10:   flit_count <= flit_count + 1'b1;
            2'b01:   flit_count <= flit_count - 1'b1;
            default: flit_count <= flit_count;
         endcase
         // Complete packets, counted in at the tail and out at the tail
         case ({in_xfer & in_last, out_xfer & out_last})
            2'b10:   pkt_count <= pkt_count + 1'b1;
            2'b01:   pkt_count <= pkt_count - 1'b1;
            default: pkt_count <= pkt_count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/l2r_request_parser.sv
// L2R request parser
// Decodes packet headers, takes the address flit and offers each payload
// flit as an addressed write beat; other packet types are drained
`timescale 1ns/1ps
`default_nettype none

module l2r_request_parser import dma_target_pkg::*; (
   input  wire          clk,
   input  wire          rst,
   input  flit_t        flit_i,
   input  wire          flit_valid_i,
   output logic         flit_ready_o,
   dma_beat_if.parser   beat
);

   typedef enum logic [1:0] {
      st_idle,
      st_get_addr,
      st_data,
      st_discard
   } state_t;

   state_t     state;
   state_t     next_state;
   // Running write address
   word_t      wr_adr;
   // Header context of the current packet
   tile_id_t   dest_q;
   packet_id_t packet_id_q;
   logic       req_last_q;
   logic       flit_last;
   logic       is_l2r;
   logic       beat_xfer;

   assign flit_last = (flit_i[flit_type_msb:flit_type_lsb] == flit_type_last) |
                      (flit_i[flit_type_msb:flit_type_lsb] == flit_type_single);
   assign is_l2r    = (flit_i[packet_type_msb:packet_type_lsb] == packet_type_l2r_req);
   assign beat_xfer = beat.valid & beat.ready;

   // Beat payload follows the buffer head directly
   assign beat.adr         = wr_adr;
   assign beat.dat         = flit_i[content_msb:content_lsb];
   assign beat.last_beat   = flit_last;
   assign beat.resp_needed = flit_last & req_last_q;
   assign beat.dest        = dest_q;
   assign beat.packet_id   = packet_id_q;

   always_comb begin
      next_state   = state;
      flit_ready_o = 1'b0;
      beat.valid   = 1'b0;
      case (state)
         st_idle: begin
            flit_ready_o = 1'b1;
            // Header-only packets carry nothing to write
            if (flit_valid_i && !flit_last) begin
               next_state = is_l2r ? st_get_addr : st_discard;
            end
         end
         st_get_addr: begin
            flit_ready_o = 1'b1;
            if (flit_valid_i) begin
               next_state = flit_last ? st_idle : st_data;
            end
         end
         st_data: begin
            // Held beat stalls the buffer output
            beat.valid   = flit_valid_i;
            flit_ready_o = beat.ready;
            if (beat_xfer && flit_last) next_state = st_idle;
         end
         default: begin
            flit_ready_o = 1'b1;
            if (flit_valid_i && flit_last) next_state = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) state <= st_idle;
      else state <= next_state;
   end

   always_ff @(posedge clk) begin
      // Latch response context from the header
      if (state == st_idle && flit_valid_i) begin
         dest_q      <= flit_i[source_msb:source_lsb];
         packet_id_q <= flit_i[packet_id_msb:packet_id_lsb];
         req_last_q  <= flit_i[req_last_bit];
      end
      if (state == st_get_addr && flit_valid_i) begin
         wr_adr <= flit_i[content_msb:content_lsb];
      end else if (beat_xfer) begin
         wr_adr <= wr_adr + word_bytes;
      end
   end

endmodule

`default_nettype wire

//--- verilog/wb_write_master.sv
// Wishbone write master
// Holds one beat and drives it as a burst write until acked, then raises
// a response request for the final beat of a request-last packet
`timescale 1ns/1ps
`default_nettype none

module wb_write_master import dma_target_pkg::*; (
   input  wire          clk,
   input  wire          rst,
   dma_beat_if.master   beat,
   dma_resp_if.master   resp,
   output logic         wb_cyc_o,
   output logic         wb_stb_o,
   output logic         wb_we_o,
   output word_t        wb_adr_o,
   output word_t        wb_dat_o,
   output logic [2:0]   wb_cti_o,
   input  wire          wb_ack_i
);

   logic       busy;
   logic       resp_valid;
   // Held beat
   word_t      adr_q;
   word_t      dat_q;
   logic       last_q;
   logic       resp_needed_q;
   tile_id_t   dest_q;
   packet_id_t packet_id_q;
   logic       beat_xfer;

   // Empty, or finishing a beat that needs no response
   assign beat.ready = (!busy & !resp_valid) | (busy & wb_ack_i & !resp_needed_q);
   assign beat_xfer  = beat.valid & beat.ready;

   assign wb_cyc_o = busy;
   assign wb_stb_o = busy;
   assign wb_we_o  = busy;
   assign wb_adr_o = adr_q;
   assign wb_dat_o = dat_q;
   assign wb_cti_o = last_q ? cti_end : cti_incr;

   // No new beat while pending, so held context stays valid
   assign resp.valid     = resp_valid;
   assign resp.dest      = dest_q;
   assign resp.packet_id = packet_id_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy       <= 1'b0;
         resp_valid <= 1'b0;
      end else begin
         if (beat_xfer) busy <= 1'b1;
         else if (wb_ack_i) busy <= 1'b0;
         if (busy && wb_ack_i && resp_needed_q) resp_valid <= 1'b1;
         else if (resp.ready) resp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (beat_xfer) begin
         adr_q         <= beat.adr;
         dat_q         <= beat.dat;
         last_q        <= beat.last_beat;
         resp_needed_q <= beat.resp_needed;
         dest_q        <= beat.dest;
         packet_id_q   <= beat.packet_id;
      end
   end

endmodule

`default_nettype wire

//--- verilog/l2r_response_sender.sv
// L2R response sender
// Builds the single-flit L2R response and holds it until the NoC takes it
`timescale 1ns/1ps
`default_nettype none

module l2r_response_sender import dma_target_pkg::*; (
   input  wire          clk,
   input  wire          rst,
   dma_resp_if.sender   resp,
   output flit_t        noc_out_flit_o,
   output logic         noc_out_valid_o,
   input  wire          noc_out_ready_i
);

   logic  full_q;
   flit_t flit_q;
   flit_t resp_flit;

   // One flit slot
   assign resp.ready      = !full_q;
   assign noc_out_valid_o = full_q;
   assign noc_out_flit_o  = flit_q;

   // Unused header fields stay zero
   always_comb begin
      resp_flit = '0;
      resp_flit[flit_type_msb:flit_type_lsb]       = flit_type_single;
      resp_flit[dest_msb:dest_lsb]                 = resp.dest;
      resp_flit[packet_class_msb:packet_class_lsb] = packet_class_dma;
      resp_flit[packet_id_msb:packet_id_lsb]       = resp.packet_id;
      resp_flit[packet_type_msb:packet_type_lsb]   = packet_type_l2r_resp;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         full_q <= 1'b0;
      end else if (resp.valid && resp.ready) begin
         full_q <= 1'b1;
      end else if (noc_out_ready_i) begin
         full_q <= 1'b0;
      end
   end

   // Captured only when empty, so stable under back-pressure
   always_ff @(posedge clk) begin
      if (resp.valid && resp.ready) flit_q <= resp_flit;
   end

endmodule

`default_nettype wire

//--- verilog/dma_target.sv
// DMA write target top level
// NoC packet buffer, L2R request parser, Wishbone write master and
// response sender in a pipeline behind plain NoC and Wishbone ports
`timescale 1ns/1ps
`default_nettype none

module dma_target import dma_target_pkg::*; #(
   parameter int packet_depth = 16
) (
   input  wire         clk,
   input  wire         rst,
   // NoC input
   input  flit_t       noc_in_flit_i,
   input  wire         noc_in_valid_i,
   output logic        noc_in_ready_o,
   // NoC output
   output flit_t       noc_out_flit_o,
   output logic        noc_out_valid_o,
   input  wire         noc_out_ready_i,
   // Wishbone master
   output logic        wb_cyc_o,
   output logic        wb_stb_o,
   output logic        wb_we_o,
   output word_t       wb_adr_o,
   output word_t       wb_dat_o,
   output logic [2:0]  wb_cti_o,
   input  wire         wb_ack_i
);

   // Buffer to parser flit stream
   flit_t buf_flit;
   logic  buf_valid;
   logic  buf_ready;

   dma_beat_if beat_if ();
   dma_resp_if resp_if ();

   noc_packet_buffer #(
      .packet_depth (packet_depth)
   ) u_buffer (
      .clk         (clk),
      .rst         (rst),
      .in_flit_i   (noc_in_flit_i),
      .in_valid_i  (noc_in_valid_i),
      .in_ready_o  (noc_in_ready_o),
      .out_flit_o  (buf_flit),
      .out_valid_o (buf_valid),
      .out_ready_i (buf_ready)
   );

   l2r_request_parser u_parser (
      .clk          (clk),
      .rst          (rst),
      .flit_i       (buf_flit),
      .flit_valid_i (buf_valid),
      .flit_ready_o (buf_ready),
      .beat         (beat_if.parser)
   );

   wb_write_master u_master (
      .clk      (clk),
      .rst      (rst),
      .beat     (beat_if.master),
      .resp     (resp_if.master),
      .wb_cyc_o (wb_cyc_o),
      .wb_stb_o (wb_stb_o),
      .wb_we_o  (wb_we_o),
      .wb_adr_o (wb_adr_o),
      .wb_dat_o (wb_dat_o),
      .wb_cti_o (wb_cti_o),
      .wb_ack_i (wb_ack_i)
   );

   l2r_response_sender u_sender (
      .clk             (clk),
      .rst             (rst),
      .resp            (resp_if.sender),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i)
   );

endmodule

`default_nettype wire

//--- test/tb_clkgen.sv
// Testbench clock and reset source
// Free-running clock, synchronous reset held high for a few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
   parameter int half_period  = 2,
   parameter int reset_cycles = 2
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(half_period) clk_o = ~clk_o;
   end

   // Release just after an edge, like other driven inputs
   initial begin
      rst_o = 1'b1;
      repeat (reset_cycles) @(posedge clk_o);
      #1;
      rst_o = 1'b0;
   end

endmodule

`default_nettype wire

//--- test/dma_target_chk.sv
// Protocol assertions for the DMA write target
// Bound into the top level; Wishbone strobe rules, held outputs, reset state
`timescale 1ns/1ps
`default_nettype none

module dma_target_chk import dma_target_pkg::*; (
   input wire        clk,
   input wire        rst,
   input wire flit_t noc_out_flit_i,
   input wire        noc_out_valid_i,
   input wire        noc_out_ready_i,
   input wire        wb_cyc_i,
   input wire        wb_stb_i,
   input wire        wb_we_i,
   input wire word_t wb_adr_i,
   input wire word_t wb_dat_i,
   input wire        wb_ack_i
);

   // Write-only master
   stb_implies_cyc_we: assert property (@(posedge clk) disable iff (rst)
      wb_stb_i |-> (wb_cyc_i && wb_we_i))
      else $error("Wishbone strobe without cycle or write enable");

   // Response flit held under back-pressure
   noc_out_held: assert property (@(posedge clk) disable iff (rst)
      (noc_out_valid_i && !noc_out_ready_i) |=> (noc_out_valid_i && $stable(noc_out_flit_i)))
      else $error("NoC output flit changed before it was accepted");

   // Beat held until acked
   wb_beat_held: assert property (@(posedge clk) disable iff (rst)
      (wb_stb_i && !wb_ack_i) |=> (wb_stb_i && $stable(wb_adr_i) && $stable(wb_dat_i)))
      else $error("Wishbone address or data changed before ack");

   reset_idle: assert property (@(posedge clk)
      rst |=> (!noc_out_valid_i && !wb_cyc_i))
      else $error("Outputs active in the cycle after reset");

endmodule

`default_nettype wire

//--- test/tb_dma_target.sv
// Testbench for the DMA write target
// Sends L2R and other packets, models a Wishbone slave with random ack delay
// and a NoC sink with random ready, and checks writes and responses in order
`timescale 1ns/1ps
`default_nettype none

module tb_dma_target import dma_target_pkg::*; ();

   localparam int packet_depth   = 16;
   localparam int random_packets = 12;
   localparam int num_packets    = 9 + random_packets;
   localparam int cycle_limit    = 200 * num_packets + 100;

   // Write record {adr, dat, cti}, response flit zero-extended
   typedef logic [66:0] record_t;

   logic        clk;
   logic        rst;
   flit_t       noc_in_flit_i;
   logic        noc_in_valid_i;
   logic        noc_in_ready_o;
   flit_t       noc_out_flit_o;
   logic        noc_out_valid_o;
   logic        noc_out_ready_i;
   logic        wb_cyc_o;
   logic        wb_stb_o;
   logic        wb_we_o;
   word_t       wb_adr_o;
   word_t       wb_dat_o;
   logic [2:0]  wb_cti_o;
   logic        wb_ack_i;

   record_t     exp_wr[$];
   record_t     got_wr[$];
   record_t     exp_resp[$];
   record_t     got_resp[$];
   flit_t       pkt_q[$];
   integer      seed = 32'h97f7;
   int          error_count = 0;
   int          writes_seen = 0;
   int          resps_seen = 0;
   int          packets_sent = 0;
   int          cycle_count = 0;

   tb_clkgen u_clkgen (
      .clk_o (clk),
      .rst_o (rst)
   );

   dma_target #(
      .packet_depth (packet_depth)
   ) dut (
      .clk             (clk),
      .rst             (rst),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .wb_cyc_o        (wb_cyc_o),
      .wb_stb_o        (wb_stb_o),
      .wb_we_o         (wb_we_o),
      .wb_adr_o        (wb_adr_o),
      .wb_dat_o        (wb_dat_o),
      .wb_cti_o        (wb_cti_o),
      .wb_ack_i        (wb_ack_i)
   );

   bind dma_target dma_target_chk u_chk (
      .clk             (clk),
      .rst             (rst),
      .noc_out_flit_i  (noc_out_flit_o),
      .noc_out_valid_i (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .wb_cyc_i        (wb_cyc_o),
      .wb_stb_i        (wb_stb_o),
      .wb_we_i         (wb_we_o),
      .wb_adr_i        (wb_adr_o),
      .wb_dat_i        (wb_dat_o),
      .wb_ack_i        (wb_ack_i)
   );

   task automatic check_value(input string what, input record_t got, input record_t exp);
      if (got !== exp) begin
         error_count++;
         $display("** Error @ %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
      end
   endtask

   // Header, address flit, then words payload flits; final flit typed last
   function automatic void build_packet(input logic [1:0] ptype, input logic req_last,
                                        input tile_id_t src, input packet_id_t pid,
                                        input word_t base, input int words);
      flit_t f;
      int    i;
      pkt_q.delete();
      f = '0;
      f[flit_type_msb:flit_type_lsb]       = flit_type_header;
      f[packet_class_msb:packet_class_lsb] = packet_class_dma;
      f[packet_id_msb:packet_id_lsb]       = pid;
      f[packet_type_msb:packet_type_lsb]   = ptype;
      f[req_last_bit]                      = req_last;
      f[source_msb:source_lsb]             = src;
      pkt_q.push_back(f);
      pkt_q.push_back({(words == 0) ? flit_type_last : flit_type_payload, base});
      for (i = 0; i < words; i++) begin
         pkt_q.push_back({(i == words - 1) ? flit_type_last : flit_type_payload,
                          word_t'($random(seed))});
      end
   endfunction

   // Reference model of one packet
   function automatic void predict_packet(input flit_t pkt[$]);
      word_t adr;
      int    last_idx;
      int    i;
      last_idx = pkt.size() - 1;
      if (pkt[0][packet_type_msb:packet_type_lsb] != packet_type_l2r_req) return;
      adr = pkt[1][content_msb:content_lsb];
      for (i = 2; i <= last_idx; i++) begin
         exp_wr.push_back({adr, pkt[i][content_msb:content_lsb],
                           (i == last_idx) ? cti_end : cti_incr});
         adr = adr + word_bytes;
      end
      // Response goes back to the requesting tile
      if (pkt[0][req_last_bit]) begin
         exp_resp.push_back(record_t'({flit_type_single, pkt[0][source_msb:source_lsb],
                                       packet_class_dma, pkt[0][packet_id_msb:packet_id_lsb],
                                       packet_type_l2r_resp, 18'd0}));
      end
   endfunction

   // Called 1 ns after an edge; random idle cycles of up to max_gap per flit
   task automatic send_packet(input int max_gap);
      int   k;
      int   gap;
      logic taken;
      predict_packet(pkt_q);
      packets_sent++;
      for (k = 0; k < pkt_q.size(); k++) begin
         gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         noc_in_flit_i  = pkt_q[k];
         noc_in_valid_i = 1'b1;
         do begin
            @(negedge clk);
            taken = noc_in_ready_o;
            @(posedge clk);
            #1;
         end while (!taken);
         noc_in_valid_i = 1'b0;
      end
   endtask

   // Wishbone slave; outputs sampled mid-cycle, ack driven after the edge
   initial begin : wb_slave
      int   delay;
      logic armed;
      logic xfer;
      wb_ack_i = 1'b0;
      armed    = 1'b0;
      delay    = 0;
      forever begin
         @(negedge clk);
         xfer = wb_cyc_o & wb_stb_o & wb_ack_i;
         if (xfer) begin
            got_wr.push_back({wb_adr_o, wb_dat_o, wb_cti_o});
            // Every beat of this target is a write
            check_value("write enable", record_t'(wb_we_o), record_t'(1'b1));
         end
         @(posedge clk);
         #1;
         if (xfer) begin
            wb_ack_i = 1'b0;
            armed    = 1'b0;
         end
         // New beat on the bus, 0 to 3 wait cycles
         if (wb_cyc_o && wb_stb_o && !armed) begin
            delay = int'($unsigned($random(seed)) % 4);
            armed = 1'b1;
         end
         if (armed) begin
            if (delay == 0) wb_ack_i = 1'b1;
            else delay--;
         end
      end
   end

   // NoC sink, ready about three cycles in four
   initial begin : noc_sink
      logic xfer;
      noc_out_ready_i = 1'b0;
      forever begin
         @(negedge clk);
         xfer = noc_out_valid_o & noc_out_ready_i;
         if (xfer) got_resp.push_back(record_t'(noc_out_flit_o));
         @(posedge clk);
         #1;
         noc_out_ready_i = (($random(seed) & 3) != 0);
      end
   end

   always @(posedge clk) begin : compare
      record_t item;
      while (got_wr.size() > 0) begin
         item = got_wr.pop_front();
         writes_seen++;
         if (exp_wr.size() == 0) begin
            error_count++;
            $display("Unexpected Wishbone write %h with no write outstanding", item);
         end else begin
            check_value("write {adr,dat,cti}", item, exp_wr.pop_front());
         end
      end
      while (got_resp.size() > 0) begin
         item = got_resp.pop_front();
         resps_seen++;
         if (exp_resp.size() == 0) begin
            error_count++;
            $display("Unexpected response flit %h with no response outstanding", item);
         end else begin
            check_value("response flit", item, exp_resp.pop_front());
         end
      end
   end

   initial begin : watchdog
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout after %0d cycles, %0d writes and %0d responses never arrived",
               cycle_limit, exp_wr.size(), exp_resp.size());
      $display("Simulation failed");
      $finish;
   end

   initial begin : stimulus
      int         n;
      logic [1:0] ptype;
      logic       req_last;
      tile_id_t   src;
      word_t      base;
      int         words;
      noc_in_flit_i  = '0;
      noc_in_valid_i = 1'b0;
      @(negedge rst);
      // Burst with response, then a burst without one
      build_packet(packet_type_l2r_req, 1'b1, 5'd7, 4'd3, 32'h0000_1000, 4);
      send_packet(0);
      build_packet(packet_type_l2r_req, 1'b0, 5'd9, 4'd4, 32'h0000_2000, 3);
      send_packet(0);
      // Dropped types followed by a valid request
      build_packet(packet_type_r2l_req, 1'b1, 5'd2, 4'd5, 32'h0000_0000, 0);
      send_packet(0);
      build_packet(2'd3, 1'b1, 5'd2, 4'd6, 32'h0000_3000, 1);
      send_packet(0);
      build_packet(packet_type_l2r_req, 1'b1, 5'd12, 4'd7, 32'h0000_4000, 2);
      send_packet(0);
      // Single words
      build_packet(packet_type_l2r_req, 1'b1, 5'd3, 4'd8, 32'h0000_5000, 1);
      send_packet(0);
      build_packet(packet_type_l2r_req, 1'b0, 5'd4, 4'd9, 32'h0000_5100, 1);
      send_packet(2);
      // Buffer-sized packet, back-to-back then with gaps
      build_packet(packet_type_l2r_req, 1'b1, 5'd30, 4'd10, 32'h0001_0000, packet_depth - 2);
      send_packet(0);
      send_packet(3);
      // Mixed traffic
      for (n = 0; n < random_packets; n++) begin
         ptype    = (($random(seed) & 7) == 0) ? packet_type_r2l_req : packet_type_l2r_req;
         req_last = (($random(seed) & 1) != 0);
         src      = tile_id_t'($random(seed));
         base     = word_t'($random(seed)) & 32'hffff_fffc;
         words    = 1 + int'($unsigned($random(seed)) % (packet_depth - 2));
         build_packet(ptype, req_last, src, packet_id_t'(n), base, words);
         send_packet(3);
      end
      while (exp_wr.size() != 0 || exp_resp.size() != 0) @(posedge clk);
      // Quiet window for late duplicates
      repeat (20) @(posedge clk);
      $display("Checked %0d packets, %0d writes, %0d responses, %0d errors",
               packets_sent, writes_seen, resps_seen, error_count);
      if (error_count == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
verilog/dma_target_pkg.sv
verilog/dma_beat_if.sv
verilog/dma_resp_if.sv
verilog/noc_packet_buffer.sv
verilog/l2r_request_parser.sv
verilog/wb_write_master.sv
verilog/l2r_response_sender.sv
verilog/dma_target.sv
test/tb_clkgen.sv
test/dma_target_chk.sv
test/tb_dma_target.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the DMA target testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_dma_target -f filelist.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/Vtb_dma_target > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation run exited with status $status"
   exit 1
fi

if grep -q "Simulation failed" "$log"; then
   exit 1
fi
exit 0
